// File: Makefile
TOP  := spdma_tb
SRCS := $(filter-out +%,$(shell cat list.f))

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f include/spdma_cfg.svh $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module spdma_top

clean:
	rm -rf obj_dir sim.log

// File: dv/spdma_tb.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module spdma_tb;

  localparam int dw          = `SPDMA_DATA_WIDTH;
  localparam int n_acc       = `SPDMA_ACCEL_COUNT;
  localparam int addr_w      = `SPDMA_ADDR_WIDTH;
  localparam int len_w       = `SPDMA_LEN_WIDTH;
  localparam int bpl         = dw / 8;
  localparam int ub          = $clog2(bpl);
  localparam int id_w        = $clog2(n_acc);
  localparam int line_w      = addr_w - ub;
  localparam int mem_bytes   = 2 ** addr_w;
  // Descriptors sent over the whole run
  localparam int desc_total  = 19;
  localparam int stall_len   = 40;
  localparam int cycle_limit = 60 * desc_total + stall_len + 200;
  localparam int stop_window = 8;
  localparam int ready_on    = 0;
  localparam int ready_rand  = 1;
  localparam int ready_off   = 2;

  logic                    clk;
  logic                    rst;
  logic                    wr_en;
  logic [line_w-1:0]       wr_addr;
  logic [dw-1:0]           wr_data;
  logic                    desc_valid;
  logic [id_w-1:0]         desc_accel_id;
  logic [addr_w-1:0]       desc_addr;
  logic [len_w-1:0]        desc_len;
  logic [n_acc-1:0]        accel_stop;
  logic [n_acc-1:0]        accel_busy;
  logic [n_acc*dw-1:0]     m_tdata;
  logic [n_acc*ub-1:0]     m_tuser;
  logic [n_acc-1:0]        m_tlast;
  logic [n_acc-1:0]        m_tvalid;
  logic [n_acc-1:0]        m_tready;

  // Byte copy of the scratchpad and expected beats per accelerator
  logic [7:0]    mem_copy [mem_bytes];
  logic [dw-1:0] exp_data [n_acc][$];
  int            exp_user [n_acc][$];
  bit            exp_last [n_acc][$];
  int            beat_count [n_acc];
  int            ready_mode [n_acc];
  string         test_name = "reset";
  int            mismatch_errors = 0;
  int            assert_errors = 0;
  int            other_errors = 0;
  int            cycle_count = 0;

  spdma_top i_spdma_top (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .desc_valid    (desc_valid),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .accel_stop    (accel_stop),
    .accel_busy    (accel_busy),
    .m_tdata       (m_tdata),
    .m_tuser       (m_tuser),
    .m_tlast       (m_tlast),
    .m_tvalid      (m_tvalid),
    .m_tready      (m_tready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Ready pattern per accelerator, mode taken at the edge and driven after it
  initial begin : drive_ready
    int mode [n_acc];
    m_tready = '1;
    for (int i = 0; i < n_acc; i++) begin
      ready_mode[i] = ready_on;
    end
    forever begin
      @(posedge clk);
      mode = ready_mode;
      #2;
      for (int i = 0; i < n_acc; i++) begin
        case (mode[i])
          ready_rand: m_tready[i] = 1'($urandom_range(0, 1));
          ready_off:  m_tready[i] = 1'b0;
          default:    m_tready[i] = 1'b1;
        endcase
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  for (genvar g = 0; g < n_acc; g++) begin : g_check
    // A stalled beat stays put until it is taken
    assert property (@(posedge clk) disable iff (rst)
      m_tvalid[g] && !m_tready[g] |=> m_tvalid[g] && $stable(m_tdata[g*dw +: dw]) &&
        $stable(m_tuser[g*ub +: ub]) && $stable(m_tlast[g]))
    else begin
      assert_errors++;
      $display("Accelerator %0d changed or dropped a stalled beat in %s", g, test_name);
    end

    assert property (@(posedge clk) disable iff (rst)
      desc_valid && desc_accel_id == id_w'(g) |-> ##2 accel_busy[g])
    else begin
      assert_errors++;
      $display("Accelerator %0d did not turn busy after its descriptor", g);
    end

    assert property (@(posedge clk) disable iff (rst)
      m_tvalid[g] && m_tready[g] && m_tlast[g] |=> !accel_busy[g])
    else begin
      assert_errors++;
      $display("Accelerator %0d stayed busy after its last beat", g);
    end

    assert property (@(posedge clk) disable iff (rst)
      accel_stop[g] |-> ##stop_window (!accel_busy[g] && !m_tvalid[g]))
    else begin
      assert_errors++;
      $display("Accelerator %0d still busy or valid after stop", g);
    end
  end

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // Beat k carries bytes a+4k up to a+4k+3, lowest address in the low byte
  task automatic add_expected(input int id, input int addr, input int len);
    int            nbeats;
    logic [dw-1:0] word;
    nbeats = (len + bpl - 1) / bpl;
    for (int k = 0; k < nbeats; k++) begin
      for (int j = 0; j < bpl; j++) begin
        word[j*8 +: 8] = mem_copy[(addr + k * bpl + j) % mem_bytes];
      end
      exp_data[id].push_back(word);
      exp_user[id].push_back((k == nbeats - 1) ? (len - 1) % bpl : bpl - 1);
      exp_last[id].push_back(k == nbeats - 1);
    end
  endtask

  task automatic send_desc(input int id, input int addr, input int len);
    add_expected(id, addr, len);
    desc_valid    = 1'b1;
    desc_accel_id = id_w'(id);
    desc_addr     = addr_w'(addr);
    desc_len      = len_w'(len);
    step(1);
    desc_valid = 1'b0;
  endtask

  task automatic check_beat(input int id);
    logic [dw-1:0] act_data;
    logic [dw-1:0] exp_word;
    logic [dw-1:0] mask;
    int            act_user;
    int            exp_u;
    bit            exp_l;
    act_data = m_tdata[id*dw +: dw];
    act_user = int'(m_tuser[id*ub +: ub]);
    beat_count[id]++;
    if (exp_data[id].size() == 0) begin
      other_errors++;
      $display("Accelerator %0d delivered a beat nobody asked for in %s", id, test_name);
    end else begin
      exp_word = exp_data[id].pop_front();
      exp_u    = exp_user[id].pop_front();
      exp_l    = exp_last[id].pop_front();
      // Only bytes up to the last valid index count
      mask = '0;
      for (int j = 0; j <= exp_u; j++) begin
        mask[j*8 +: 8] = 8'hff;
      end
      if ((act_data & mask) !== (exp_word & mask)) begin
        mismatch_errors++;
        $display("MISMATCH %s accel %0d data: expected %h, actual %h",
                 test_name, id, exp_word & mask, act_data & mask);
      end
      if (act_user != exp_u) begin
        mismatch_errors++;
        $display("MISMATCH %s accel %0d tuser: expected %0d, actual %0d",
                 test_name, id, exp_u, act_user);
      end
      if (m_tlast[id] !== exp_l) begin
        mismatch_errors++;
        $display("MISMATCH %s accel %0d tlast: expected %0b, actual %0b",
                 test_name, id, exp_l, m_tlast[id]);
      end
    end
  endtask

  // Mid-cycle sample, the beat is taken at the next rising edge
  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < n_acc; i++) begin
        if (m_tvalid[i] && m_tready[i]) begin
          check_beat(i);
        end
      end
    end
  end

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int i = 0; i < n_acc; i++) begin
      total += exp_data[i].size();
    end
    return total;
  endfunction

  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (accel_busy != '0 || pending_beats() != 0);
    step(1);
  endtask

  task automatic preload_memory();
    logic [dw-1:0] word;
    for (int l = 0; l < mem_bytes / bpl; l++) begin
      word    = $urandom;
      wr_en   = 1'b1;
      wr_addr = line_w'(l);
      wr_data = word;
      for (int j = 0; j < bpl; j++) begin
        mem_copy[l * bpl + j] = word[j*8 +: 8];
      end
      step(1);
    end
    wr_en = 1'b0;
  endtask

  initial begin : main
    int start;
    rst           = 1'b1;
    wr_en         = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    desc_valid    = 1'b0;
    desc_accel_id = '0;
    desc_addr     = '0;
    desc_len      = '0;
    accel_stop    = '0;
    void'($urandom(89374));
    step(3);
    rst = 1'b0;
    @(negedge clk);
    assert (m_tvalid == '0 && accel_busy == '0)
    else begin
      assert_errors++;
      $display("Streams valid or accelerators busy right after reset");
    end
    step(1);
    preload_memory();

    test_name = "aligned";
    send_desc(0, 'h00, 4);
    send_desc(1, 'h40, 64);
    wait_idle();

    // Includes a transfer that runs past the last line
    test_name = "unaligned";
    send_desc(2, 'h13, 23);
    send_desc(3, 'hf6, 30);
    send_desc(0, 'h01, 3);
    send_desc(1, 'hfd, 7);
    wait_idle();

    test_name = "four_streams";
    for (int i = 0; i < n_acc; i++) begin
      ready_mode[i] = ready_rand;
    end
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < n_acc; i++) begin
        send_desc(i, $urandom_range(0, mem_bytes - 1), $urandom_range(1, 64));
      end
      wait_idle();
    end
    for (int i = 0; i < n_acc; i++) begin
      ready_mode[i] = ready_on;
    end
    step(2);

    test_name = "stall";
    ready_mode[1] = ready_off;
    step(1);
    send_desc(1, 'h2a, 48);
    while (!m_tvalid[1]) begin
      @(negedge clk);
    end
    step(stall_len);
    ready_mode[1] = ready_on;
    wait_idle();

    test_name = "stop";
    send_desc(0, 'h21, 120);
    send_desc(2, 'h80, 60);
    send_desc(3, 'hc3, 44);
    start = beat_count[0];
    while (beat_count[0] < start + 3) begin
      @(negedge clk);
    end
    step(1);
    accel_stop[0] = 1'b1;
    step(1);
    accel_stop[0] = 1'b0;
    step(stop_window);
    // Nothing more may arrive for the stopped stream
    exp_data[0].delete();
    exp_user[0].delete();
    exp_last[0].delete();
    wait_idle();
    step(10);

    test_name = "restart";
    send_desc(0, 'h35, 20);
    wait_idle();

    $display("Errors: %0d mismatch, %0d assertion, %0d other",
             mismatch_errors, assert_errors, other_errors);
    if (mismatch_errors + assert_errors + other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: hw/accel_queue.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module accel_queue import spdma_pkg::*; #(
  parameter int idx = 0
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         clear,
  input  logic                         issue_hot,
  input  beat_t                        beat,
  input  logic                         beat_we,
  input  logic [dest_width-1:0]        beat_dest,
  output logic                         credit_ok,
  output logic                         done,
  output logic [`SPDMA_DATA_WIDTH-1:0] m_tdata,
  output logic [mask_bits-1:0]         m_tuser,
  output logic                         m_tlast,
  output logic                         m_tvalid,
  input  logic                         m_tready
);

  localparam int depth     = `SPDMA_FIFO_LINES;
  localparam int ptr_width = $clog2(depth);

  beat_t              mem [depth];
  // Pointers carry one wrap bit above the index
  logic [ptr_width:0] wr_ptr;
  logic [ptr_width:0] rd_ptr;
  // Lines issued to this accelerator and not yet popped
  logic [ptr_width:0] credit_cnt;
  logic               push;
  logic               pop;
  beat_t              head;

  assign push      = beat_we && (beat_dest == dest_width'(idx)) && !clear;
  assign head      = mem[rd_ptr[ptr_width-1:0]];
  assign m_tvalid  = (wr_ptr != rd_ptr);
  assign pop       = m_tvalid && m_tready;
  assign done      = pop && head.last;
  assign credit_ok = (credit_cnt < (ptr_width + 1)'(depth));
  assign m_tdata   = head.data;
  assign m_tuser   = head.last_idx;
  assign m_tlast   = head.last;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[ptr_width-1:0]] <= beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      credit_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({issue_hot, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: hw/bank_ram.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module bank_ram import spdma_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wr_en,
  input  logic [line_addr_width-1:0]   wr_addr,
  input  logic [`SPDMA_DATA_WIDTH-1:0] wr_data,
  input  logic                         rd_en0,
  input  logic [bank_addr_width-1:0]   rd_addr0,
  input  logic                         rd_en1,
  input  logic [bank_addr_width-1:0]   rd_addr1,
  output logic [`SPDMA_DATA_WIDTH-1:0] rd_data0,
  output logic [`SPDMA_DATA_WIDTH-1:0] rd_data1
);

  localparam int bank_depth = 2 ** bank_addr_width;

  logic                         rd_en   [2];
  logic [bank_addr_width-1:0]   rd_addr [2];
  logic [`SPDMA_DATA_WIDTH-1:0] rd_data [2];

  assign rd_en[0]   = rd_en0;
  assign rd_en[1]   = rd_en1;
  assign rd_addr[0] = rd_addr0;
  assign rd_addr[1] = rd_addr1;
  assign rd_data0   = rd_data[0];
  assign rd_data1   = rd_data[1];

  // Bank b holds the lines whose low address bit equals b
  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [`SPDMA_DATA_WIDTH-1:0] mem [bank_depth];

    always_ff @(posedge clk) begin
      if (wr_en && (wr_addr[0] == 1'(b))) begin
        mem[wr_addr[line_addr_width-1:1]] <= wr_data;
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        rd_data[b] <= '0;
      end else if (rd_en[b]) begin
        rd_data[b] <= mem[rd_addr[b]];
      end
    end
  end

endmodule

// File: hw/desc_decode.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module desc_decode import spdma_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         desc_valid,
  input  logic [dest_width-1:0]        desc_accel_id,
  input  logic [`SPDMA_ADDR_WIDTH-1:0] desc_addr,
  input  logic [`SPDMA_LEN_WIDTH-1:0]  desc_len,
  output rd_req_t                      req,
  output logic                         req_valid
);

  logic [mask_bits-1:0]      tail_bytes;
  logic [line_cnt_width-1:0] full_lines;

  assign tail_bytes = desc_len[mask_bits-1:0];
  assign full_lines = line_cnt_width'(desc_len[`SPDMA_LEN_WIDTH-1:mask_bits]);

  always_ff @(posedge clk) begin
    if (desc_valid) begin
      req.dest      <= desc_accel_id;
      req.line_addr <= desc_addr[`SPDMA_ADDR_WIDTH-1:mask_bits];
      req.offset    <= desc_addr[mask_bits-1:0];
      // Round up when the length ends inside a line
      req.line_cnt  <= full_lines + line_cnt_width'(tail_bytes != '0);
      // A zero tail wraps to the full-line index
      req.final_idx <= tail_bytes - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= desc_valid;
    end
  end

endmodule

// File: hw/rd_align.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module rd_align import spdma_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  rd_issue_if.align                    issue,
  input  logic [`SPDMA_DATA_WIDTH-1:0] rd_data0,
  input  logic [`SPDMA_DATA_WIDTH-1:0] rd_data1,
  output beat_t                        beat,
  output logic                         beat_we,
  output logic [dest_width-1:0]        beat_dest
);

  localparam int dw = `SPDMA_DATA_WIDTH;

  // Stage 1 lines up with the bank read, stage 2 with the registered data
  logic                  v1, v2;
  logic [dest_width-1:0] dest1, dest2;
  logic [mask_bits-1:0]  off1, off2;
  logic [mask_bits-1:0]  idx1, idx2;
  logic                  last1, last2;
  logic                  bank1, bank2;
  logic [dw-1:0]         data0_r, data1_r;
  logic [2*dw-1:0]       pair;
  logic [2*dw-1:0]       shifted;

  // Lower line goes in the low half
  assign pair    = bank2 ? {data0_r, data1_r} : {data1_r, data0_r};
  assign shifted = pair >> {off2, 3'b000};

  always_ff @(posedge clk) begin
    dest1         <= issue.dest;
    off1          <= issue.offset;
    idx1          <= issue.last_idx;
    last1         <= issue.last;
    bank1         <= issue.bank;
    dest2         <= dest1;
    off2          <= off1;
    idx2          <= idx1;
    last2         <= last1;
    bank2         <= bank1;
    data0_r       <= rd_data0;
    data1_r       <= rd_data1;
    beat.data     <= shifted[dw-1:0];
    beat.last_idx <= idx2;
    beat.last     <= last2;
    beat_dest     <= dest2;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v1      <= 1'b0;
      v2      <= 1'b0;
      beat_we <= 1'b0;
    end else begin
      v1      <= issue.valid;
      v2      <= v1;
      beat_we <= v2;
    end
  end

endmodule

// File: hw/rd_sched.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module rd_sched import spdma_pkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  rd_req_t                       req,
  input  logic                          req_valid,
  input  logic [`SPDMA_ACCEL_COUNT-1:0] accel_stop,
  input  logic [`SPDMA_ACCEL_COUNT-1:0] credit_ok,
  input  logic [`SPDMA_ACCEL_COUNT-1:0] done,
  output logic                          rd_en0,
  output logic                          rd_en1,
  output logic [bank_addr_width-1:0]    rd_addr0,
  output logic [bank_addr_width-1:0]    rd_addr1,
  rd_issue_if.sched                     issue,
  output logic [`SPDMA_ACCEL_COUNT-1:0] issue_hot,
  output logic [`SPDMA_ACCEL_COUNT-1:0] stop_lat,
  output logic [`SPDMA_ACCEL_COUNT-1:0] accel_busy
);

  localparam int accel_count = `SPDMA_ACCEL_COUNT;

  // Active transfer table, one entry per accelerator
  rd_req_t                    tbl [accel_count];
  logic [accel_count-1:0]     act_v;
  logic [accel_count-1:0]     act_v_nxt;
  logic [accel_count-1:0]     stop_r;
  logic [dest_width-1:0]      rr_ptr;

  logic [accel_count-1:0]     new_hot;
  logic [accel_count-1:0]     rr_req;
  logic                       rr_found;
  logic [dest_width-1:0]      rr_idx;
  logic                       grant_any;
  rd_req_t                    sel;
  rd_req_t                    sel_nxt;
  logic                       sel_last;
  logic [line_addr_width-1:0] sel_addr_n;

  assign new_hot = req_valid ? (accel_count'(1) << req.dest) : '0;

  // A new descriptor lifts the stop of its accelerator right away
  assign stop_lat = stop_r & ~new_hot;

  assign rr_req = act_v & credit_ok & ~stop_r;

  // Round robin, search starts one past the last grant
  always_comb begin : rr_pick
    int cand;
    rr_found = 1'b0;
    rr_idx   = '0;
    for (int k = 1; k <= accel_count; k++) begin
      cand = (int'(rr_ptr) + k) % accel_count;
      if (!rr_found && rr_req[cand]) begin
        rr_found = 1'b1;
        rr_idx   = dest_width'(cand);
      end
    end
  end

  // New request wins over the table
  assign grant_any  = req_valid || rr_found;
  assign sel        = req_valid ? req : tbl[rr_idx];
  assign sel_last   = (sel.line_cnt == line_cnt_width'(1));
  assign sel_addr_n = sel.line_addr + 1'b1;
  assign issue_hot  = grant_any ? (accel_count'(1) << sel.dest) : '0;

  always_comb begin
    sel_nxt           = sel;
    sel_nxt.line_addr = sel_addr_n;
    sel_nxt.line_cnt  = sel.line_cnt - 1'b1;
    act_v_nxt         = act_v;
    if (grant_any) begin
      act_v_nxt[sel.dest] = !sel_last;
    end
  end

  always_ff @(posedge clk) begin
    if (grant_any) begin
      tbl[sel.dest] <= sel_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_v      <= '0;
      stop_r     <= '0;
      accel_busy <= '0;
      rr_ptr     <= '0;
    end else begin
      act_v      <= act_v_nxt & ~stop_lat;
      stop_r     <= (stop_r | accel_stop) & ~new_hot;
      accel_busy <= ((accel_busy & ~done) | new_hot) & ~stop_lat;
      if (!req_valid && rr_found) begin
        rr_ptr <= rr_idx;
      end
    end
  end

  // Even bank gets whichever of A and A+1 is even
  always_ff @(posedge clk) begin
    rd_addr0       <= sel.line_addr[0] ? sel_addr_n[line_addr_width-1:1]
                                       : sel.line_addr[line_addr_width-1:1];
    rd_addr1       <= sel.line_addr[line_addr_width-1:1];
    issue.dest     <= sel.dest;
    issue.offset   <= sel.offset;
    issue.last_idx <= sel_last ? sel.final_idx : '1;
    issue.last     <= sel_last;
    issue.bank     <= sel.line_addr[0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en0      <= 1'b0;
      rd_en1      <= 1'b0;
      issue.valid <= 1'b0;
    end else begin
      rd_en0      <= grant_any;
      rd_en1      <= grant_any;
      issue.valid <= grant_any;
    end
  end

endmodule

// File: hw/spdma_if.sv
`timescale 1ns/1ps

// One line read issued by the scheduler, seen by the alignment stage
interface rd_issue_if import spdma_pkg::*; ();

  logic                  valid;
  logic [dest_width-1:0] dest;
  // Byte offset of the transfer inside its first line
  logic [mask_bits-1:0]  offset;
  // Last valid byte of the resulting beat
  logic [mask_bits-1:0]  last_idx;
  logic                  last;
  // Low bit of the line address, tells which bank holds the lower line
  logic                  bank;

  modport sched (
    output valid,
    output dest,
    output offset,
    output last_idx,
    output last,
    output bank
  );

  modport align (
    input valid,
    input dest,
    input offset,
    input last_idx,
    input last,
    input bank
  );

endinterface

// File: hw/spdma_pkg.sv
`include "spdma_cfg.svh"

package spdma_pkg;

  // Byte index inside one line
  localparam int mask_bits = $clog2(`SPDMA_DATA_WIDTH / 8);
  localparam int line_addr_width = `SPDMA_ADDR_WIDTH - mask_bits;
  // Even and odd lines split over two banks
  localparam int bank_addr_width = line_addr_width - 1;
  // One extra bit so the longest transfer's line count fits
  localparam int line_cnt_width = `SPDMA_LEN_WIDTH - mask_bits + 1;
  localparam int dest_width = $clog2(`SPDMA_ACCEL_COUNT);

  typedef struct packed {
    logic [dest_width-1:0]      dest;
    logic [line_addr_width-1:0] line_addr;
    logic [line_cnt_width-1:0]  line_cnt;
    logic [mask_bits-1:0]       offset;
    logic [mask_bits-1:0]       final_idx;
  } rd_req_t;

  typedef struct packed {
    logic [`SPDMA_DATA_WIDTH-1:0] data;
    logic [mask_bits-1:0]         last_idx;
    logic                         last;
  } beat_t;

endpackage

// File: hw/spdma_top.sv
`timescale 1ns/1ps

`include "spdma_cfg.svh"

module spdma_top import spdma_pkg::*; (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            wr_en,
  input  logic [line_addr_width-1:0]                      wr_addr,
  input  logic [`SPDMA_DATA_WIDTH-1:0]                    wr_data,
  input  logic                                            desc_valid,
  input  logic [dest_width-1:0]                           desc_accel_id,
  input  logic [`SPDMA_ADDR_WIDTH-1:0]                    desc_addr,
  input  logic [`SPDMA_LEN_WIDTH-1:0]                     desc_len,
  input  logic [`SPDMA_ACCEL_COUNT-1:0]                   accel_stop,
  output logic [`SPDMA_ACCEL_COUNT-1:0]                   accel_busy,
  output logic [`SPDMA_ACCEL_COUNT*`SPDMA_DATA_WIDTH-1:0] m_tdata,
  output logic [`SPDMA_ACCEL_COUNT*mask_bits-1:0]         m_tuser,
  output logic [`SPDMA_ACCEL_COUNT-1:0]                   m_tlast,
  output logic [`SPDMA_ACCEL_COUNT-1:0]                   m_tvalid,
  input  logic [`SPDMA_ACCEL_COUNT-1:0]                   m_tready
);

  localparam int accel_count = `SPDMA_ACCEL_COUNT;
  localparam int dw          = `SPDMA_DATA_WIDTH;

  rd_req_t                    req;
  logic                       req_valid;
  logic                       rd_en0, rd_en1;
  logic [bank_addr_width-1:0] rd_addr0, rd_addr1;
  logic [dw-1:0]              rd_data0, rd_data1;
  logic [accel_count-1:0]     issue_hot;
  logic [accel_count-1:0]     stop_lat;
  logic [accel_count-1:0]     credit_ok;
  logic [accel_count-1:0]     done;
  beat_t                      beat;
  logic                       beat_we;
  logic [dest_width-1:0]      beat_dest;

  rd_issue_if i_issue ();

  bank_ram i_bank_ram (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_en0   (rd_en0),
    .rd_addr0 (rd_addr0),
    .rd_en1   (rd_en1),
    .rd_addr1 (rd_addr1),
    .rd_data0 (rd_data0),
    .rd_data1 (rd_data1)
  );

  desc_decode i_desc_decode (
    .clk           (clk),
    .rst           (rst),
    .desc_valid    (desc_valid),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .req           (req),
    .req_valid     (req_valid)
  );

  rd_sched i_rd_sched (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .accel_stop (accel_stop),
    .credit_ok  (credit_ok),
    .done       (done),
    .rd_en0     (rd_en0),
    .rd_en1     (rd_en1),
    .rd_addr0   (rd_addr0),
    .rd_addr1   (rd_addr1),
    .issue      (i_issue),
    .issue_hot  (issue_hot),
    .stop_lat   (stop_lat),
    .accel_busy (accel_busy)
  );

  rd_align i_rd_align (
    .clk       (clk),
    .rst       (rst),
    .issue     (i_issue),
    .rd_data0  (rd_data0),
    .rd_data1  (rd_data1),
    .beat      (beat),
    .beat_we   (beat_we),
    .beat_dest (beat_dest)
  );

  // One output FIFO and credit counter per accelerator
  for (genvar i = 0; i < accel_count; i++) begin : g_queue
    accel_queue #(
      .idx (i)
    ) i_accel_queue (
      .clk       (clk),
      .rst       (rst),
      .clear     (stop_lat[i]),
      .issue_hot (issue_hot[i]),
      .beat      (beat),
      .beat_we   (beat_we),
      .beat_dest (beat_dest),
      .credit_ok (credit_ok[i]),
      .done      (done[i]),
      .m_tdata   (m_tdata[i*dw +: dw]),
      .m_tuser   (m_tuser[i*mask_bits +: mask_bits]),
      .m_tlast   (m_tlast[i]),
      .m_tvalid  (m_tvalid[i]),
      .m_tready  (m_tready[i])
    );
  end

endmodule

// File: include/spdma_cfg.svh
`ifndef SPDMA_CFG_SVH
`define SPDMA_CFG_SVH

// Bits per scratchpad line and per output beat
`define SPDMA_DATA_WIDTH 32

// Byte address width of the scratchpad
`define SPDMA_ADDR_WIDTH 8

// Number of accelerators served
`define SPDMA_ACCEL_COUNT 4

// Byte length width of a descriptor
`define SPDMA_LEN_WIDTH 7

// Lines per output FIFO, power of two
`define SPDMA_FIFO_LINES 2

`endif

// File: list.f
+incdir+include
hw/spdma_pkg.sv
hw/spdma_if.sv
hw/desc_decode.sv
hw/rd_sched.sv
hw/bank_ram.sv
hw/rd_align.sv
hw/accel_queue.sv
hw/spdma_top.sv
dv/spdma_tb.sv
